/* i2f_cfg_pkg.sv */
// integer-to-float APB peripheral configuration: register map, CTRL and SCAN layout
package i2f_cfg_pkg;

  // integer width used when the top level is not overridden
  localparam int unsigned int_width_dflt = 32;

  // byte offsets of the four registers within the 16-byte window
  localparam logic [3:0] addr_operand = 4'h0;
  localparam logic [3:0] addr_ctrl    = 4'h4;
  localparam logic [3:0] addr_result  = 4'h8;
  localparam logic [3:0] addr_scan    = 4'hC;

  // CTRL holds a single mode bit
  // when it is set the operand is read as two's complement
  localparam int unsigned ctrl_signed_bit = 0;

  // each count field in SCAN is six bits wide
  // this leaves room for integer widths up to 64
  localparam int unsigned scan_cnt_width = 6;

  // leading-zero count of the magnitude occupies bits 5:0
  localparam int unsigned scan_lz_lsb = 0;

  // trailing-zero count of the magnitude occupies bits 13:8
  localparam int unsigned scan_tz_lsb = 8;

  // set when the operand was zero, both counts then read as width minus one
  localparam int unsigned scan_zero_bit = 16;

  // set when rounding dropped nonzero bits
  localparam int unsigned scan_inexact_bit = 17;

endpackage

/* fp_types_pkg.sv */
// IEEE-754 single-precision format: field widths, exponent bias and word views
package fp_types_pkg;

  // biased exponent field width
  localparam int unsigned exp_width = 8;

  // stored fraction width, the hidden one is not part of it
  localparam int unsigned frac_width = 23;

  // exponent bias, a value of 1.0 carries exponent 127
  localparam int unsigned exp_bias = 127;

  // the three fields in the order they sit in the word, sign on top
  typedef struct packed {
    logic                  sign;
    logic [exp_width-1:0]  exponent;
    logic [frac_width-1:0] fraction;
  } fp32_fields_t;

  // one result word seen two ways
  // the rounder builds it field by field
  // the register block and bus only ever see the raw bits
  typedef union packed {
    logic [31:0]  raw;
    fp32_fields_t fields;
  } fp32_word_u;

endpackage

/* lzc_versacore.sv */
// zero counter from the LSB or the MSB, built as a binary selection tree
`timescale 1ns/100ps

module lzc_versacore #(
  parameter int unsigned WIDTH = 2,
  parameter bit          MODE  = 1'b0
) (
  input  logic [WIDTH-1:0]         in,
  output logic [$clog2(WIDTH)-1:0] cnt,
  output logic                     empty
);

  // depth of the tree, one level per index bit
  localparam int unsigned levels = $clog2(WIDTH);
  localparam int unsigned nodes  = 2 ** levels;
  // keep the index storage at least one bit wide for the degenerate case
  localparam int unsigned iw     = (levels > 0) ? levels : 1;
  // a full tree has nodes-1 entries, a single bit still needs one
  localparam int unsigned heap   = (levels > 0) ? nodes - 1 : 1;

  logic [WIDTH-1:0]         vec;
  logic [heap-1:0]          sel;
  logic [heap-1:0][iw-1:0]  idx;

  // a zero-width vector cannot be counted at all
  if (WIDTH < 1) begin : g_bad_width
    $fatal(1, "lzc_versacore needs WIDTH of at least one");
  end

  // in leading mode the vector is mirrored, so both modes search from bit 0
  always_comb begin
    for (int unsigned i = 0; i < WIDTH; i++) begin
      vec[i] = MODE ? in[WIDTH-1-i] : in[i];
    end
  end

  // nodes are stored heap style, node n has children 2n+1 and 2n+2
  // each node reports whether its subtree holds a set bit and the lowest such index
  for (genvar lv = 0; lv < levels; lv++) begin : g_lvl
    for (genvar k = 0; k < 2 ** lv; k++) begin : g_node
      localparam int unsigned n = 2 ** lv - 1 + k;
      if (lv == levels - 1) begin : g_leaf
        if (2 * k + 1 < WIDTH) begin : g_pair
          // the lower bit wins, otherwise point at the upper one
          assign sel[n] = vec[2*k] | vec[2*k+1];
          assign idx[n] = vec[2*k] ? iw'(2 * k) : iw'(2 * k + 1);
        end else if (2 * k < WIDTH) begin : g_single
          assign sel[n] = vec[2*k];
          assign idx[n] = iw'(2 * k);
        end else begin : g_pad
          // padding leaf beyond the input width never wins
          assign sel[n] = 1'b0;
          assign idx[n] = '0;
        end
      end else begin : g_inner
        localparam int unsigned c = 2 * n + 1;
        // prefer the left subtree, it covers the lower positions
        assign sel[n] = sel[c] | sel[c+1];
        assign idx[n] = sel[c] ? idx[c] : idx[c+1];
      end
    end
  end

  // a single-bit input has no tree, its only node is the bit itself
  if (levels == 0) begin : g_root
    assign sel[0] = vec[0];
    assign idx[0] = '0;
  end

  // an all-zero input follows the rightmost path and yields WIDTH-1 for power-of-two widths
  assign cnt   = idx[0];
  assign empty = ~sel[0];

endmodule

/* int_normalizer.sv */
// conversion stage one: magnitude, zero counts and left normalization of the operand
`timescale 1ns/100ps

module int_normalizer #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         start,
  input  logic [INT_WIDTH-1:0]         operand,
  input  logic                         is_signed,
  output logic                         s1_valid,
  output logic                         s1_sign,
  output logic [INT_WIDTH-1:0]         s1_mag_norm,
  output logic [$clog2(INT_WIDTH)-1:0] s1_lz,
  output logic [$clog2(INT_WIDTH)-1:0] s1_tz,
  output logic                         s1_zero
);

  localparam int unsigned lz_w = $clog2(INT_WIDTH);

  logic                 neg;
  logic [INT_WIDTH-1:0] mag;
  logic [lz_w-1:0]      lead_cnt;
  logic [lz_w-1:0]      trail_cnt;
  logic                 mag_zero;

  // only a signed operand with its top bit set is negative
  assign neg = is_signed & operand[INT_WIDTH-1];

  // two's complement negation, the most negative value maps onto 2^(INT_WIDTH-1)
  assign mag = neg ? -operand : operand;

  // leading zeros give the normalizing shift distance
  lzc_versacore #(
    .WIDTH (INT_WIDTH),
    .MODE  (1'b1)
  ) u_lzc_lead (
    .in    (mag),
    .cnt   (lead_cnt),
    .empty (mag_zero)
  );

  // trailing zeros only feed the scan register
  lzc_versacore #(
    .WIDTH (INT_WIDTH),
    .MODE  (1'b0)
  ) u_lzc_trail (
    .in    (mag),
    .cnt   (trail_cnt),
    .empty ()
  );

  // valid follows start by one edge, there is no stall inside the pipeline
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= start;
    end
  end

  // payload is captured only when a new operand arrives
  always_ff @(posedge clk) begin
    if (start) begin
      s1_sign     <= neg;
      s1_mag_norm <= mag << lead_cnt;
      s1_lz       <= lead_cnt;
      s1_tz       <= trail_cnt;
      s1_zero     <= mag_zero;
    end
  end

  // the counter and the shifter together must land the top set bit in the MSB
  a_norm_msb : assert property (
    @(posedge clk) disable iff (!arst_n)
    (s1_valid && !s1_zero) |-> s1_mag_norm[INT_WIDTH-1]
  );

endmodule

/* fp_rounder.sv */
// conversion stage two: exponent, round to nearest even and fp32 packing
`timescale 1ns/100ps

module fp_rounder #(
  parameter int unsigned INT_WIDTH = 32
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         s1_valid,
  input  logic                         s1_sign,
  input  logic [INT_WIDTH-1:0]         s1_mag_norm,
  input  logic [$clog2(INT_WIDTH)-1:0] s1_lz,
  input  logic [$clog2(INT_WIDTH)-1:0] s1_tz,
  input  logic                         s1_zero,
  output logic                         result_valid,
  output fp_types_pkg::fp32_word_u     result,
  output logic                         inexact,
  output logic                         res_zero,
  output logic [$clog2(INT_WIDTH)-1:0] res_lz,
  output logic [$clog2(INT_WIDTH)-1:0] res_tz
);

  localparam int unsigned frac_w = fp_types_pkg::frac_width;
  localparam int unsigned exp_w  = fp_types_pkg::exp_width;
  // bits below the hidden one, padded so guard and sticky always exist
  localparam int unsigned ext_w  = INT_WIDTH - 1 + frac_w + 2;

  logic [ext_w-1:0]         ext;
  logic [frac_w-1:0]        frac_trunc;
  logic                     guard;
  logic                     sticky;
  logic                     round_up;
  logic [frac_w:0]          frac_rnd;
  logic [exp_w-1:0]         exp_base;
  logic [exp_w-1:0]         exp_final;
  fp_types_pkg::fp32_word_u packed_word;

  // drop the hidden one and left-align what remains
  assign ext        = {s1_mag_norm[INT_WIDTH-2:0], {(frac_w + 2){1'b0}}};
  assign frac_trunc = ext[ext_w-1 -: frac_w];
  assign guard      = ext[ext_w-1-frac_w];
  assign sticky     = |ext[ext_w-2-frac_w:0];

  // round up above the halfway point, and on a tie only if the kept LSB is odd
  assign round_up = guard & (sticky | frac_trunc[0]);
  assign frac_rnd = {1'b0, frac_trunc} + {{frac_w{1'b0}}, round_up};

  // the top set bit sits at position INT_WIDTH-1-lz of the original magnitude
  assign exp_base  = exp_w'(fp_types_pkg::exp_bias + INT_WIDTH - 1 - s1_lz);
  // a carry out of the fraction leaves it all zero and bumps the exponent
  assign exp_final = exp_base + {{(exp_w - 1){1'b0}}, frac_rnd[frac_w]};

  // zero has no hidden one, so it bypasses the packing and reads as +0
  always_comb begin
    if (s1_zero) begin
      packed_word.raw = '0;
    end else begin
      packed_word.fields.sign     = s1_sign;
      packed_word.fields.exponent = exp_final;
      packed_word.fields.fraction = frac_rnd[frac_w-1:0];
    end
  end

  // result_valid is a single-cycle strobe one edge after s1_valid
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= s1_valid;
    end
  end

  // the counts ride along unchanged for the scan register
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result   <= packed_word;
      inexact  <= guard | sticky;
      res_zero <= s1_zero;
      res_lz   <= s1_lz;
      res_tz   <= s1_tz;
    end
  end

  // an integer never converts to a denormal, an infinity or a NaN
  a_exp_range : assert property (
    @(posedge clk) disable iff (!arst_n)
    (result_valid && !res_zero) |->
      (result.fields.exponent != '0) && (result.fields.exponent != '1)
  );

endmodule

/* i2f_apb_regs.sv */
// APB3 register block of the converter: operand, control, result and scan registers
`timescale 1ns/100ps

module i2f_apb_regs (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic [3:0]                                  paddr,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  logic [31:0]                                 pwdata,
  output logic [31:0]                                 prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  output logic                                        start,
  output logic [31:0]                                 operand,
  output logic                                        is_signed,
  input  logic                                        busy_s1,
  input  logic                                        result_valid,
  input  fp_types_pkg::fp32_word_u                    result,
  input  logic                                        inexact,
  input  logic                                        res_zero,
  input  logic [i2f_cfg_pkg::scan_cnt_width-1:0]      res_lz,
  input  logic [i2f_cfg_pkg::scan_cnt_width-1:0]      res_tz
);

  localparam int unsigned cnt_w = i2f_cfg_pkg::scan_cnt_width;

  logic        access;
  logic        hit_op;
  logic        hit_ctrl;
  logic        hit_res;
  logic        hit_scan;
  logic        bad;
  logic        rd_stall;
  logic        wr_done;
  logic [31:0] operand_q;
  logic        ctrl_signed_q;
  logic [31:0] result_q;
  logic [31:0] scan_q;
  logic [31:0] scan_word;

  // access phase of an APB transfer
  assign access   = psel & penable;
  assign hit_op   = (paddr == i2f_cfg_pkg::addr_operand);
  assign hit_ctrl = (paddr == i2f_cfg_pkg::addr_ctrl);
  assign hit_res  = (paddr == i2f_cfg_pkg::addr_result);
  assign hit_scan = (paddr == i2f_cfg_pkg::addr_scan);

  // unmapped offsets and writes to the read-only pair are rejected
  assign bad = ~(hit_op | hit_ctrl | hit_res | hit_scan) | (pwrite & (hit_res | hit_scan));

  // result reads wait while anything is still in flight
  // so they always return the newest conversion
  assign rd_stall = ~pwrite & (hit_res | hit_scan) & (busy_s1 | result_valid | start);

  assign pready  = access & ~rd_stall;
  assign pslverr = access & bad;

  // writes never stall, so the access phase is also the completing cycle
  assign wr_done = access & pwrite & ~bad;

  // stage one samples pwdata on the same edge that completes the write
  assign start     = wr_done & hit_op;
  assign operand   = pwdata;
  assign is_signed = ctrl_signed_q;

  // SCAN layout comes from the configuration package, unused bits read zero
  always_comb begin
    scan_word = '0;
    scan_word[i2f_cfg_pkg::scan_lz_lsb +: cnt_w] = res_lz;
    scan_word[i2f_cfg_pkg::scan_tz_lsb +: cnt_w] = res_tz;
    scan_word[i2f_cfg_pkg::scan_zero_bit]        = res_zero;
    scan_word[i2f_cfg_pkg::scan_inexact_bit]     = inexact;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      operand_q     <= '0;
      ctrl_signed_q <= 1'b0;
      result_q      <= '0;
      scan_q        <= '0;
    end else begin
      if (start) begin
        operand_q <= pwdata;
      end
      if (wr_done && hit_ctrl) begin
        ctrl_signed_q <= pwdata[i2f_cfg_pkg::ctrl_signed_bit];
      end
      // each conversion lands here exactly once, on its result_valid strobe
      if (result_valid) begin
        result_q <= result.raw;
        scan_q   <= scan_word;
      end
    end
  end

  // read data is a plain mux, a rejected read returns zero
  always_comb begin
    prdata = '0;
    if (hit_op) begin
      prdata = operand_q;
    end else if (hit_ctrl) begin
      prdata[i2f_cfg_pkg::ctrl_signed_bit] = ctrl_signed_q;
    end else if (hit_res) begin
      prdata = result_q;
    end else if (hit_scan) begin
      prdata = scan_q;
    end
  end

  // the slave only answers inside an access phase
  a_resp_in_access : assert property (
    @(posedge clk) disable iff (!arst_n)
    (pready || pslverr) |-> (psel && penable)
  );

  // the two-stage pipeline drains in at most two cycles, so a stall is short
  a_stall_bounded : assert property (
    @(posedge clk) disable iff (!arst_n)
    (access && rd_stall) |-> ##[1:2] pready
  );

endmodule

/* i2f_apb_top.sv */
// top level of the APB integer-to-float converter, register block plus two pipeline stages
`timescale 1ns/100ps

module i2f_apb_top #(
  parameter int unsigned INT_WIDTH = i2f_cfg_pkg::int_width_dflt
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [3:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  localparam int unsigned lz_w  = $clog2(INT_WIDTH);
  localparam int unsigned cnt_w = i2f_cfg_pkg::scan_cnt_width;

  // launch from the register block
  logic                     start;
  logic [31:0]              operand;
  logic                     is_signed;

  // stage one to stage two
  logic                     s1_valid;
  logic                     s1_sign;
  logic [INT_WIDTH-1:0]     s1_mag_norm;
  logic [lz_w-1:0]          s1_lz;
  logic [lz_w-1:0]          s1_tz;
  logic                     s1_zero;

  // stage two back to the register block
  logic                     result_valid;
  fp_types_pkg::fp32_word_u result;
  logic                     inexact;
  logic                     res_zero;
  logic [lz_w-1:0]          res_lz;
  logic [lz_w-1:0]          res_tz;

  i2f_apb_regs u_regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .start        (start),
    .operand      (operand),
    .is_signed    (is_signed),
    .busy_s1      (s1_valid),
    .result_valid (result_valid),
    .result       (result),
    .inexact      (inexact),
    .res_zero     (res_zero),
    // counts are zero-extended into the six-bit SCAN fields
    .res_lz       (cnt_w'(res_lz)),
    .res_tz       (cnt_w'(res_tz))
  );

  // only the low INT_WIDTH bits of the bus word form the integer
  int_normalizer #(
    .INT_WIDTH (INT_WIDTH)
  ) u_norm (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .operand     (operand[INT_WIDTH-1:0]),
    .is_signed   (is_signed),
    .s1_valid    (s1_valid),
    .s1_sign     (s1_sign),
    .s1_mag_norm (s1_mag_norm),
    .s1_lz       (s1_lz),
    .s1_tz       (s1_tz),
    .s1_zero     (s1_zero)
  );

  fp_rounder #(
    .INT_WIDTH (INT_WIDTH)
  ) u_round (
    .clk          (clk),
    .arst_n       (arst_n),
    .s1_valid     (s1_valid),
    .s1_sign      (s1_sign),
    .s1_mag_norm  (s1_mag_norm),
    .s1_lz        (s1_lz),
    .s1_tz        (s1_tz),
    .s1_zero      (s1_zero),
    .result_valid (result_valid),
    .result       (result),
    .inexact      (inexact),
    .res_zero     (res_zero),
    .res_lz       (res_lz),
    .res_tz       (res_tz)
  );

endmodule

/* tb_i2f_model.svh */
// reference model of the integer-to-float conversion and of the SCAN fields
`ifndef TB_I2F_MODEL_SVH
`define TB_I2F_MODEL_SVH

// included inside the testbench module, it relies on int_w, cnt_w, exp_w and frac_w there

// absolute value of the operand as seen in the low int_w bits
function automatic logic [63:0] magnitude_of(logic [31:0] value, logic signed_mode);
  logic [63:0] v;
  v = 64'(value) & ((64'd1 << int_w) - 1);
  // in signed mode the top bit of the integer marks a negative value
  if (signed_mode && v[int_w-1]) begin
    return (64'd1 << int_w) - v;
  end
  return v;
endfunction

// position of the most significant one, or -1 for zero
function automatic int highest_set_bit(logic [63:0] mag);
  int pos;
  pos = -1;
  for (int i = 0; i < int_w; i++) begin
    if (mag[i]) pos = i;
  end
  return pos;
endfunction

// position of the least significant one, or -1 for zero
function automatic int lowest_set_bit(logic [63:0] mag);
  int pos;
  pos = -1;
  for (int i = int_w - 1; i >= 0; i--) begin
    if (mag[i]) pos = i;
  end
  return pos;
endfunction

// true when bits below the kept 24 are nonzero
function automatic logic rounding_inexact(logic [31:0] value, logic signed_mode);
  logic [63:0] mag;
  int hi;
  mag = magnitude_of(value, signed_mode);
  hi = highest_set_bit(mag);
  if (hi <= int'(frac_w)) return 1'b0;
  return (mag & ((64'd1 << (hi - frac_w)) - 1)) != 0;
endfunction

// expected fp32 word, round to nearest with ties to even
function automatic fp_types_pkg::fp32_word_u int_to_fp32(logic [31:0] value,
                                                          logic signed_mode);
  fp_types_pkg::fp32_word_u w;
  logic [63:0] mag;
  logic [63:0] kept;
  logic [63:0] rest;
  logic [63:0] half;
  int hi;
  int shift;
  int unsigned exp_val;
  mag = magnitude_of(value, signed_mode);
  hi = highest_set_bit(mag);
  w.raw = '0;
  // zero converts to +0
  if (hi < 0) return w;
  // a value of 2^hi carries exponent bias plus hi
  exp_val = fp_types_pkg::exp_bias + hi;
  if (hi <= int'(frac_w)) begin
    kept = mag << (frac_w - hi);
  end else begin
    shift = hi - frac_w;
    kept = mag >> shift;
    rest = mag & ((64'd1 << shift) - 1);
    half = 64'd1 << (shift - 1);
    if (rest > half || (rest == half && kept[0])) kept = kept + 1;
  end
  // rounding may carry past the hidden one, which doubles the value
  if (kept[frac_w+1]) begin
    kept = kept >> 1;
    exp_val++;
  end
  w.fields.sign     = signed_mode & value[int_w-1];
  w.fields.exponent = exp_w'(exp_val);
  w.fields.fraction = kept[frac_w-1:0];
  return w;
endfunction

// expected SCAN word, built from the field positions of the register map
function automatic logic [31:0] scan_fields(logic [31:0] value, logic signed_mode);
  logic [63:0] mag;
  logic [31:0] word;
  int hi;
  int lz;
  int tz;
  mag = magnitude_of(value, signed_mode);
  hi = highest_set_bit(mag);
  // a zero operand reports the largest count in both fields
  lz = (hi < 0) ? int_w - 1 : int_w - 1 - hi;
  tz = (hi < 0) ? int_w - 1 : lowest_set_bit(mag);
  word = '0;
  word[i2f_cfg_pkg::scan_lz_lsb +: cnt_w] = cnt_w'(lz);
  word[i2f_cfg_pkg::scan_tz_lsb +: cnt_w] = cnt_w'(tz);
  word[i2f_cfg_pkg::scan_zero_bit]        = (hi < 0);
  word[i2f_cfg_pkg::scan_inexact_bit]     = rounding_inexact(value, signed_mode);
  return word;
endfunction

`endif

/* tb_i2f_apb.sv */
// testbench of the APB integer-to-float converter, random and directed operands against a model
`timescale 1ns/100ps

module tb_i2f_apb;

  localparam int int_w        = i2f_cfg_pkg::int_width_dflt;
  localparam int cnt_w        = i2f_cfg_pkg::scan_cnt_width;
  localparam int exp_w        = fp_types_pkg::exp_width;
  localparam int frac_w       = fp_types_pkg::frac_width;
  localparam int reset_cycles = 16;
  localparam int num_random   = 400;
  // random conversions plus an upper bound on the directed ones
  localparam int num_ops        = num_random + 32;
  localparam int timeout_cycles = 20 * num_ops + reset_cycles;

  logic        clk;
  logic        arst_n;
  logic [3:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int cycle_count = 0;
  fp_types_pkg::fp32_word_u last_expected;

  // values near rounding ties, carries and the signed limits
  logic [31:0] corner_vals [8] = '{32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF, 32'h0100_0001,
                                   32'h0100_0003, 32'h0200_0002, 32'h00FF_FFFF, 32'h0000_0000};

  `include "tb_i2f_model.svh"

  i2f_apb_top dut0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #2 clk = ~clk;

  // the run may not outlast a generous budget per conversion
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      stop_with_failure($sformatf("timeout: the run did not finish within %0d cycles",
                                  timeout_cycles));
    end
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_fp32(input fp_types_pkg::fp32_word_u got,
                            input fp_types_pkg::fp32_word_u exp, input string what);
    if (got.raw !== exp.raw) begin
      stop_with_failure($sformatf("[FAIL] %0t ns: %s gave %h (s=%0b e=%0d f=%h), expected %h",
                                  $time, what, got.raw, got.fields.sign, got.fields.exponent,
                                  got.fields.fraction, exp.raw));
    end
  endtask

  task automatic check_scan(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %0t ns: %s SCAN %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_resp(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %0t ns: %s returned pslverr %0b, expected %0b",
                                  $time, what, got, exp));
    end
  endtask

  // access phase, sampled mid low phase and held until the slave answers
  task automatic complete_access(output logic [31:0] data, output logic err);
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge clk);
      #1;
    end
    data = prdata;
    err  = pslverr;
    // the transfer ends on this edge, the next setup phase may follow at once
    @(posedge clk);
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    complete_access(unused, err);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    complete_access(data, err);
  endtask

  task automatic release_bus();
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // reads RESULT and SCAN and compares both with the model for one operand
  task automatic read_and_compare(input logic [31:0] value, input logic signed_mode);
    logic [31:0] data;
    logic        err;
    fp_types_pkg::fp32_word_u got;
    read_reg(i2f_cfg_pkg::addr_result, data, err);
    check_resp(err, 1'b0, "RESULT read");
    got.raw = data;
    last_expected = int_to_fp32(value, signed_mode);
    check_fp32(got, last_expected, $sformatf("operand %h signed %0b", value, signed_mode));
    read_reg(i2f_cfg_pkg::addr_scan, data, err);
    check_resp(err, 1'b0, "SCAN read");
    check_scan(data, scan_fields(value, signed_mode),
               $sformatf("operand %h signed %0b", value, signed_mode));
  endtask

  // the RESULT read right after the OPERAND write hits the stall
  task automatic convert_and_check(input logic [31:0] value, input logic signed_mode);
    logic err;
    write_reg(i2f_cfg_pkg::addr_ctrl, 32'(signed_mode) << i2f_cfg_pkg::ctrl_signed_bit, err);
    check_resp(err, 1'b0, "CTRL write");
    write_reg(i2f_cfg_pkg::addr_operand, value, err);
    check_resp(err, 1'b0, "OPERAND write");
    read_and_compare(value, signed_mode);
  endtask

  initial begin
    logic [31:0] value;
    logic [31:0] data;
    logic        err;
    int unsigned kind;
    fp_types_pkg::fp32_word_u got;
    void'($urandom(86409));
    clk     = 1'b0;
    arst_n  = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (reset_cycles) @(negedge clk);
    arst_n = 1'b1;

    // unsigned ties, carries into the exponent and zero
    foreach (corner_vals[i]) convert_and_check(corner_vals[i], 1'b0);
    // zero must give both counts at their maximum and the zero flag
    read_reg(i2f_cfg_pkg::addr_scan, data, err);
    check_scan(data, (32'(int_w - 1) << i2f_cfg_pkg::scan_lz_lsb) |
                     (32'(int_w - 1) << i2f_cfg_pkg::scan_tz_lsb) |
                     (32'd1 << i2f_cfg_pkg::scan_zero_bit), "zero operand");

    // signed limits and negative values with and without rounding
    convert_and_check(32'h8000_0000, 1'b1);
    convert_and_check(32'hFFFF_FFFF, 1'b1);
    convert_and_check(32'h8000_0001, 1'b1);
    convert_and_check(32'hFF00_0001, 1'b1);
    convert_and_check(32'hFEFF_FFFF, 1'b1);
    convert_and_check(32'h7FFF_FFC0, 1'b1);

    for (int i = 0; i < num_random; i++) begin
      kind = $urandom % 4;
      case (kind)
        0: value = $urandom;
        1: value = 32'd1 << ($urandom % int_w);
        2: value = $urandom % 256;
        default: value = corner_vals[$urandom % 8];
      endcase
      convert_and_check(value, 1'(($urandom % 2)));
    end

    // two conversions in flight, the read returns the newer one
    write_reg(i2f_cfg_pkg::addr_ctrl, 32'd0, err);
    check_resp(err, 1'b0, "CTRL write");
    write_reg(i2f_cfg_pkg::addr_operand, 32'h0012_3457, err);
    check_resp(err, 1'b0, "first OPERAND write");
    write_reg(i2f_cfg_pkg::addr_operand, 32'hF7A5_1C03, err);
    check_resp(err, 1'b0, "second OPERAND write");
    read_and_compare(32'hF7A5_1C03, 1'b0);

    // rejected accesses leave RESULT as it was
    write_reg(i2f_cfg_pkg::addr_result, 32'hDEAD_BEEF, err);
    check_resp(err, 1'b1, "RESULT write");
    write_reg(i2f_cfg_pkg::addr_scan, 32'h1234_5678, err);
    check_resp(err, 1'b1, "SCAN write");
    write_reg(4'h2, 32'h0000_0001, err);
    check_resp(err, 1'b1, "unmapped write");
    read_reg(4'h6, data, err);
    check_resp(err, 1'b1, "unmapped read");
    read_reg(i2f_cfg_pkg::addr_result, data, err);
    check_resp(err, 1'b0, "RESULT read after errors");
    got.raw = data;
    check_fp32(got, last_expected, "RESULT after rejected accesses");
    release_bus();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* i2f_apb.f */
+incdir+.
i2f_cfg_pkg.sv
fp_types_pkg.sv
lzc_versacore.sv
int_normalizer.sv
fp_rounder.sv
i2f_apb_regs.sv
i2f_apb_top.sv
tb_i2f_apb.sv
